//--- logic/rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------
    // widths and constants
    // ------------------------------------------------
    localparam int xlen      = 32;
    localparam int addr_w    = 30;
    localparam int reg_idx_w = 5;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // major opcodes that the core executes
    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_lw     = 7'b0000011,
        op_sw     = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_nop = 4'd0,
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8,
        alu_slt = 4'd9
    } alu_op_e;

    // where an EX operand comes from
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    // ------------------------------------------------
    // stage payloads
    // ------------------------------------------------
    typedef struct packed {
        alu_op_e               alu_op;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_beq;
        logic                  is_bne;
        logic                  use_imm;
        logic [reg_idx_w-1:0]  rs1;
        logic [reg_idx_w-1:0]  rs2;
        logic [reg_idx_w-1:0]  rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [addr_w-1:0]     pc;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_out;
        logic [xlen-1:0]       store_data;
        logic [reg_idx_w-1:0]  rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       wb_data;
        logic [reg_idx_w-1:0]  rd;
        logic                  reg_write;
    } mem_wb_t;

endpackage

//--- logic/fwd_if.sv
`timescale 1ns/1ps

// results of the MEM and WB stages, seen by the forwarding logic
interface fwd_if import rv_pkg::*; ();

    logic [reg_idx_w-1:0] mem_rd;
    logic                 mem_reg_write;
    logic [xlen-1:0]      mem_data;

    logic [reg_idx_w-1:0] wb_rd;
    logic                 wb_reg_write;
    logic [xlen-1:0]      wb_data;

    modport src (
        output mem_rd, mem_reg_write, mem_data,
        output wb_rd, wb_reg_write, wb_data
    );

    modport sink (
        input mem_rd, mem_reg_write, mem_data,
        input wb_rd, wb_reg_write, wb_data
    );

endinterface

//--- logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t reset_val = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // bubble beats hold so a flushed slot is never kept
    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            q <= reset_val;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- logic/pc_counter.sv
`timescale 1ns/1ps

module pc_counter import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic              redirect,
    input  logic [addr_w-1:0] target,
    output logic [addr_w-1:0] pc
);

    // word address, so one step is one instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!hold) begin
            pc <= pc + addr_w'(1);
        end
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    // ID stage sources
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    input  logic                 uses_rs1,
    input  logic                 uses_rs2,
    // instruction in EX
    input  logic [reg_idx_w-1:0] ex_rd,
    input  logic                 ex_mem_read,
    input  logic [reg_idx_w-1:0] ex_rs1,
    input  logic [reg_idx_w-1:0] ex_rs2,
    input  logic                 branch_taken,
    input  logic                 jal,
    fwd_if.sink                  fwd,
    output logic                 stall,
    output logic                 flush_if_id,
    output logic                 flush_id_ex,
    output fwd_sel_e             fwd_a,
    output fwd_sel_e             fwd_b
);

    logic load_use;

    // MEM is younger than WB, so it wins
    function automatic fwd_sel_e pick_src(input logic [reg_idx_w-1:0] src);
        if (fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == src) begin
            return fwd_mem;
        end
        if (fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    // ------------------------------------------------
    // load-use
    // ------------------------------------------------
    assign load_use = ex_mem_read && ex_rd != '0 &&
                      ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

    // a taken branch throws the waiting instruction away anyway
    assign stall = load_use && !branch_taken;

    // ------------------------------------------------
    // flushes
    // ------------------------------------------------
    assign flush_if_id = branch_taken || jal;
    assign flush_id_ex = branch_taken || stall;

    assign fwd_a = pick_src(ex_rs1);
    assign fwd_b = pick_src(ex_rs2);

endmodule

//--- logic/decoder.sv
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  logic [xlen-1:0]   instr,
    input  logic [addr_w-1:0] pc,
    output id_ex_t            ctrl,
    output logic              uses_rs1,
    output logic              uses_rs2,
    output logic              jal,
    output logic [addr_w-1:0] jal_target
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] pc_byte;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_sh;
    logic [xlen-1:0] jal_byte;

    assign opcode  = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign pc_byte = {pc, 2'b00};

    // immediates
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_sh = {27'd0, instr[24:20]};

    assign jal_byte   = pc_byte + imm_j;
    assign jal_target = jal_byte[xlen-1:2];

    always_comb begin
        ctrl     = '0;
        ctrl.pc  = pc;
        ctrl.rs1 = instr[19:15];
        ctrl.rs2 = instr[24:20];
        ctrl.rd  = instr[11:7];
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        jal      = 1'b0;
        case (opcode)
            op_r_type: begin
                ctrl.reg_write = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = instr[30] ? alu_sub : alu_add;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_nop;
                endcase
            end
            op_i_type: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rs1       = 1'b1;
                ctrl.imm       = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b001:  ctrl.alu_op = alu_sll;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b101:  ctrl.alu_op = instr[30] ? alu_sra : alu_srl;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_nop;
                endcase
            end
            op_lw: begin
                ctrl.alu_op    = alu_add;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
                uses_rs1       = 1'b1;
            end
            op_sw: begin
                ctrl.alu_op    = alu_add;
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_s;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            op_branch: begin
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
                ctrl.imm    = imm_b;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
            end
            op_jal: begin
                // x0 + (pc + 4) gives the link value in EX
                jal            = 1'b1;
                ctrl.alu_op    = alu_add;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.rs1       = '0;
                ctrl.imm       = pc_byte + 32'd4;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    input  logic                 wr_en,
    input  logic [reg_idx_w-1:0] wr_idx,
    input  logic [xlen-1:0]      wr_data,
    output logic [xlen-1:0]      rd1,
    output logic [xlen-1:0]      rd2
);

    logic [xlen-1:0] regs [32];
    logic            wr_live;

    // x0 is never written, so regs[0] stays zero
    assign wr_live = wr_en && wr_idx != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // WB result is visible to ID in the same cycle
    assign rd1 = (wr_live && wr_idx == rs1) ? wr_data : regs[rs1];
    assign rd2 = (wr_live && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps

module execute import rv_pkg::*; (
    input  id_ex_t            id_ex,
    input  fwd_sel_e          fwd_a,
    input  fwd_sel_e          fwd_b,
    fwd_if.sink               fwd,
    output ex_mem_t           ex_mem,
    output logic              branch_taken,
    output logic [addr_w-1:0] branch_target
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] diff;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] tgt_byte;
    logic [4:0]      shamt;
    logic            lt;
    logic            equal;

    function automatic logic [xlen-1:0] pick(input fwd_sel_e sel, input logic [xlen-1:0] rf);
        case (sel)
            fwd_mem: return fwd.mem_data;
            fwd_wb:  return fwd.wb_data;
            default: return rf;
        endcase
    endfunction

    // ------------------------------------------------
    // operands
    // ------------------------------------------------
    assign op_a    = pick(fwd_a, id_ex.rs1_val);
    assign rs2_fwd = pick(fwd_b, id_ex.rs2_val);
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    // signed less-than from the sign of a - b, corrected when the signs differ
    assign diff = op_a - op_b;
    assign lt   = (op_a[xlen-1] ^ op_b[xlen-1]) ? op_a[xlen-1] : diff[xlen-1];

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = diff;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_xor: alu_out = op_a ^ op_b;
            alu_sll: alu_out = op_a << shamt;
            alu_srl: alu_out = op_a >> shamt;
            alu_sra: alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_slt: alu_out = {31'd0, lt};
            default: alu_out = '0;
        endcase
    end

    // branches compare the two register operands
    assign equal         = (op_a == rs2_fwd);
    assign branch_taken  = (id_ex.is_beq && equal) || (id_ex.is_bne && !equal);
    assign tgt_byte      = {id_ex.pc, 2'b00} + id_ex.imm;
    assign branch_target = tgt_byte[xlen-1:2];

    always_comb begin
        ex_mem.alu_out    = alu_out;
        ex_mem.store_data = rs2_fwd;
        ex_mem.rd         = id_ex.rd;
        ex_mem.reg_write  = id_ex.reg_write;
        ex_mem.mem_read   = id_ex.mem_read;
        ex_mem.mem_write  = id_ex.mem_write;
    end

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // instruction memory
    output logic [addr_w-1:0] imem_addr,
    input  logic [xlen-1:0]   imem_rdata,
    // data memory
    output logic              dmem_ren,
    output logic              dmem_wen,
    output logic [addr_w-1:0] dmem_addr,
    output logic [xlen-1:0]   dmem_wdata,
    input  logic [xlen-1:0]   dmem_rdata
);

    localparam int if_id_w = xlen + addr_w;

    logic [addr_w-1:0]  pc;
    logic               redirect;
    logic [addr_w-1:0]  target;
    logic [if_id_w-1:0] if_id_d;
    logic [if_id_w-1:0] if_id_q;
    id_ex_t             dec_ctrl;
    id_ex_t             id_ex_d;
    id_ex_t             id_ex_q;
    ex_mem_t            ex_mem_d;
    ex_mem_t            ex_mem_q;
    mem_wb_t            mem_wb_d;
    mem_wb_t            mem_wb_q;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               jal;
    logic [addr_w-1:0]  jal_target;
    logic [xlen-1:0]    rd1;
    logic [xlen-1:0]    rd2;
    logic               stall;
    logic               flush_if_id;
    logic               flush_id_ex;
    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    logic               branch_taken;
    logic [addr_w-1:0]  branch_target;

    fwd_if fwd_bus ();

    // ------------------------------------------------
    // IF
    // ------------------------------------------------
    // the older branch in EX outranks a JAL in ID
    assign redirect  = branch_taken || jal;
    assign target    = branch_taken ? branch_target : jal_target;
    assign imem_addr = pc;
    assign if_id_d   = {imem_rdata, pc};

    pc_counter u_pc_counter (
        .clk(clk), .rst_n(rst_n), .hold(stall),
        .redirect(redirect), .target(target), .pc(pc)
    );

    pipe_reg #(
        .payload_t(logic [if_id_w-1:0]),
        .reset_val({nop_instr, {addr_w{1'b0}}})
    ) u_if_id (
        .clk(clk), .rst_n(rst_n), .hold(stall), .bubble(flush_if_id),
        .d(if_id_d), .q(if_id_q)
    );

    // ------------------------------------------------
    // ID
    // ------------------------------------------------
    decoder u_decoder (
        .instr(if_id_q[if_id_w-1:addr_w]), .pc(if_id_q[addr_w-1:0]),
        .ctrl(dec_ctrl), .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
        .jal(jal), .jal_target(jal_target)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .rs1(dec_ctrl.rs1), .rs2(dec_ctrl.rs2),
        .wr_en(mem_wb_q.reg_write), .wr_idx(mem_wb_q.rd), .wr_data(mem_wb_q.wb_data),
        .rd1(rd1), .rd2(rd2)
    );

    always_comb begin
        id_ex_d         = dec_ctrl;
        id_ex_d.rs1_val = rd1;
        id_ex_d.rs2_val = rd2;
    end

    hazard_unit u_hazard_unit (
        .rs1(dec_ctrl.rs1), .rs2(dec_ctrl.rs2),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
        .ex_rd(id_ex_q.rd), .ex_mem_read(id_ex_q.mem_read),
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
        .branch_taken(branch_taken), .jal(jal), .fwd(fwd_bus.sink),
        .stall(stall), .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(flush_id_ex),
        .d(id_ex_d), .q(id_ex_q)
    );

    // ------------------------------------------------
    // EX
    // ------------------------------------------------
    execute u_execute (
        .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd(fwd_bus.sink),
        .ex_mem(ex_mem_d), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // ------------------------------------------------
    // MEM and WB
    // ------------------------------------------------
    assign dmem_ren   = ex_mem_q.mem_read;
    assign dmem_wen   = ex_mem_q.mem_write;
    assign dmem_addr  = ex_mem_q.alu_out[xlen-1:2];
    assign dmem_wdata = ex_mem_q.store_data;

    assign mem_wb_d.wb_data   = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_out;
    assign mem_wb_d.rd        = ex_mem_q.rd;
    assign mem_wb_d.reg_write = ex_mem_q.reg_write;

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // results offered back to EX
    assign fwd_bus.mem_rd        = ex_mem_q.rd;
    assign fwd_bus.mem_reg_write = ex_mem_q.reg_write;
    assign fwd_bus.mem_data      = ex_mem_q.alu_out;
    assign fwd_bus.wb_rd         = mem_wb_q.rd;
    assign fwd_bus.wb_reg_write  = mem_wb_q.reg_write;
    assign fwd_bus.wb_data       = mem_wb_q.wb_data;

endmodule

//--- verif/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [15:0]       lfsr_state;
logic [xlen-1:0]   prog [64];
logic [addr_w-1:0] exp_addr [$];
logic [xlen-1:0]   exp_data [$];
logic [addr_w-1:0] exp_load [$];

// --------------------------------------------------
// random bits
// --------------------------------------------------
// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

// initial data memory word for a word index
function automatic logic [31:0] fill_word(input int a);
    return 32'h1357_0000 ^ (32'(a) * 32'h0001_0421);
endfunction

// --------------------------------------------------
// instruction encoders
// --------------------------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// --------------------------------------------------
// program generator
// --------------------------------------------------
task automatic gen_program();
    int          i;
    int          off;
    logic [3:0]  kind;
    logic [3:0]  w;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [11:0] imm;
    lfsr_state = 16'd34174;
    i = 0;
    while (i < 61) begin
        kind = 4'(rand_bits(4));
        rd   = 5'(rand_bits(3));
        ra   = 5'(rand_bits(3));
        rb   = 5'(rand_bits(3));
        w    = 4'(rand_bits(4));
        // forward jumps only and never past the marker sequence
        off  = 2 + int'(rand_bits(2));
        if (i + off > 61) begin
            off = 61 - i;
        end
        if (kind < 4'd4) begin
            case (3'(rand_bits(3)))
                3'd0:       prog[i] = enc_r(7'h00, rb, ra, 3'd0, rd);
                3'd1, 3'd7: prog[i] = enc_r(7'h20, rb, ra, 3'd0, rd);
                3'd2, 3'd6: prog[i] = enc_r(7'h00, rb, ra, 3'd2, rd);
                3'd3:       prog[i] = enc_r(7'h00, rb, ra, 3'd4, rd);
                3'd4:       prog[i] = enc_r(7'h00, rb, ra, 3'd6, rd);
                default:    prog[i] = enc_r(7'h00, rb, ra, 3'd7, rd);
            endcase
        end else if (kind < 4'd8) begin
            f3 = 3'(rand_bits(3));
            if (f3 == 3'd3) begin
                f3 = 3'd0;
            end
            if (f3 == 3'd1) begin
                imm = {7'd0, 5'(rand_bits(5))};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, 1'(rand_bits(1)), 5'd0, 5'(rand_bits(5))};
            end else begin
                imm = 12'(rand_bits(12));
            end
            prog[i] = enc_i(imm, ra, f3, rd, 7'b0010011);
        end else if (kind < 4'd10) begin
            prog[i] = enc_i({6'd0, w, 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
            // use the loaded value right away
            if (i + 1 < 61) begin
                i++;
                prog[i] = enc_r(7'h00, ra, rd, 3'd0, rb);
            end
        end else if (kind < 4'd13) begin
            prog[i] = enc_s({6'd0, w, 2'b00}, rb, 5'd0);
        end else if (kind < 4'd15) begin
            prog[i] = enc_b(13'(off * 4), rb, ra, (kind == 4'd13) ? 3'b000 : 3'b001);
        end else begin
            prog[i] = enc_j(21'(off * 4), rd);
        end
        i++;
    end
    // marker store, then park on a self jump
    prog[61] = enc_i(12'h5a5, 5'd0, 3'd0, 5'd7, 7'b0010011);
    prog[62] = enc_s(12'd252, 5'd7, 5'd0);
    prog[63] = enc_j(21'd0, 5'd0);
endtask

// --------------------------------------------------
// sequential instruction-set model
// --------------------------------------------------
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] off_b;
    logic [31:0] off_j;
    int          pc;
    int          next;
    int          steps;
    for (int k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (int k = 0; k < 64; k++) begin
        mem[k] = fill_word(k);
    end
    pc    = 0;
    steps = 0;
    while (pc != 63 && steps < 1000) begin
        w     = prog[pc];
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        off_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        off_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        res   = '0;
        next  = pc + 1;
        case (w[6:0])
            7'b0110011: begin
                case (w[14:12])
                    3'd0:    res = w[30] ? a - b : a + b;
                    3'd2:    res = {31'd0, $signed(a) < $signed(b)};
                    3'd4:    res = a ^ b;
                    3'd6:    res = a | b;
                    default: res = a & b;
                endcase
                regs[w[11:7]] = res;
            end
            7'b0010011: begin
                case (w[14:12])
                    3'd0:    res = a + imm;
                    3'd1:    res = a << imm[4:0];
                    3'd2:    res = {31'd0, $signed(a) < $signed(imm)};
                    3'd4:    res = a ^ imm;
                    3'd5: begin
                        // bit 30 picks arithmetic over logical
                        if (w[30]) begin
                            res = $signed(a) >>> imm[4:0];
                        end else begin
                            res = a >> imm[4:0];
                        end
                    end
                    3'd6:    res = a | imm;
                    default: res = a & imm;
                endcase
                regs[w[11:7]] = res;
            end
            7'b0000011: begin
                ea = a + imm;
                regs[w[11:7]] = mem[ea[7:2]];
                exp_load.push_back(ea[31:2]);
            end
            7'b0100011: begin
                ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                mem[ea[7:2]] = b;
                exp_addr.push_back(ea[31:2]);
                exp_data.push_back(b);
            end
            7'b1100011: begin
                if ((w[14:12] == 3'd0) ? (a == b) : (a != b)) begin
                    next = pc + int'($signed(off_b)) / 4;
                end
            end
            7'b1101111: begin
                regs[w[11:7]] = 32'(pc * 4 + 4);
                next = pc + int'($signed(off_j)) / 4;
            end
            default: ;
        endcase
        regs[0] = '0;
        pc = next;
        steps++;
    end
endtask

`endif

//--- verif/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core import rv_pkg::*; ();

    logic              clk = 1'b0;
    logic              rst_n;
    logic [addr_w-1:0] imem_addr;
    logic [xlen-1:0]   imem_rdata;
    logic              dmem_ren;
    logic              dmem_wen;
    logic [addr_w-1:0] dmem_addr;
    logic [xlen-1:0]   dmem_wdata;
    logic [xlen-1:0]   dmem_rdata;

    logic [xlen-1:0]   dmem [64];
    logic [addr_w-1:0] act_addr [$];
    logic [xlen-1:0]   act_data [$];
    logic [addr_w-1:0] act_load [$];
    logic              marker_seen;

    `include "rv_ref_model.svh"

    always #50 clk = ~clk;

    riscv_core u_riscv_core (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
    );

    // --------------------------------------------------
    // memory models
    // --------------------------------------------------
    // fetch past the program returns a nop
    assign imem_rdata = (imem_addr < 30'd64) ? prog[imem_addr[5:0]] : 32'h0000_0013;
    assign dmem_rdata = dmem[dmem_addr[5:0]];

    // data memory writes plus the store and load logs in DUT order
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 64; k++) begin
                dmem[k] <= fill_word(k);
            end
            marker_seen <= 1'b0;
        end else begin
            if (dmem_wen) begin
                dmem[dmem_addr[5:0]] <= dmem_wdata;
                act_addr.push_back(dmem_addr);
                act_data.push_back(dmem_wdata);
                if (dmem_addr == 30'd63) begin
                    marker_seen <= 1'b1;
                end
            end
            if (dmem_ren) begin
                act_load.push_back(dmem_addr);
            end
        end
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int cycles;
        rst_n = 1'b0;
        gen_program();
        run_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (!marker_seen && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end

        if (!marker_seen) begin
            $display("no marker store from the core within 5000 cycles");
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            check_eq("store count", 32'(exp_addr.size()), 32'(act_addr.size()));
            for (int k = 0; k < exp_addr.size(); k++) begin
                check_eq($sformatf("store %0d address", k), {2'b00, exp_addr[k]},
                         {2'b00, act_addr[k]});
                check_eq($sformatf("store %0d data", k), exp_data[k], act_data[k]);
            end
            check_eq("load count", 32'(exp_load.size()), 32'(act_load.size()));
            for (int k = 0; k < exp_load.size(); k++) begin
                check_eq($sformatf("load %0d address", k), {2'b00, exp_load[k]},
                         {2'b00, act_load[k]});
            end
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+verif
logic/rv_pkg.sv
logic/fwd_if.sv
logic/pipe_reg.sv
logic/pc_counter.sv
logic/hazard_unit.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute.sv
logic/riscv_core.sv
verif/tb_riscv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_riscv_core -f list.f

out=$(./obj_dir/Vtb_riscv_core || true)
echo "$out"
if grep -q "TEST PASS" <<< "$out"; then
    exit 0
fi
exit 1
